// ==== verification/obj_input.txt ====
// first value: number of frames
// then one word per line as entry, word index, value (hex); ffff ends the list
0003
000 6 a010  // no scroll, loads master (16, 8)
000 7 0008
001 6 9004  // no scroll, loads extra (4, 2)
001 7 0002
002 0 0123  // absolute sprite at (40, 48)
002 4 0015
002 6 8028
002 7 0030
003 0 0045  // master only, lands at (80, 24)
003 4 0022
003 6 4040
003 7 0010
004 0 0067  // master and extra, lands at (116, 42)
004 4 0033
004 6 0060
004 7 0020
005 0 0089  // latched x and y, both +16, color reused
005 4 f400
005 6 8000
006 0 00ab  // latched x +16, absolute y
006 4 c044
006 6 8000
006 7 0050
007 0 0011  // x is 401, skipped
007 4 0066
007 6 8191
007 7 0010
008 0 0012  // y is 241, skipped
008 6 8020
008 7 00f1
009 0 3fff  // right at both limits
009 4 003f
009 6 8190
009 7 00f0
00a 0 0200  // latched x, color reused
00a 4 4400
00a 6 8000
00a 7 0005
00b 0 0300  // scroll sum wraps to (8, 4)
00b 4 0007
00b 6 4ff8
00b 7 0ffc
ffff

// ==== obj_engine.f ====
hw/obj_pkg.sv
hw/obj_list_reader.sv
hw/obj_position_eval.sv
hw/obj_tile_fetch.sv
hw/obj_fb_writer.sv
hw/obj_engine.sv
verification/obj_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the object engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module obj_engine_tb -f obj_engine.f -o obj_engine_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/obj_engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== verification/obj_engine_tb.sv ====
`timescale 1ns/1ps

module obj_engine_tb;
    import obj_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RAM_DEPTH    = 8192;
    localparam int STIM_DEPTH   = 256;
    localparam int IDLE_LIMIT   = 20000;
    localparam int ACK_LIMIT    = 100;
    localparam int FRAME_LIMIT  = 100000;
    localparam int SIM_LIMIT    = 500000;
    localparam int SETTLE       = 10;
    localparam logic [15:0] LFSR_SEED = 16'd64437;

    logic          clk;
    logic          rst_n;
    logic          start;
    logic          ram_rd;
    obj_ram_addr_t ram_addr;
    obj_word_t     ram_data;
    logic          tile_req;
    tile_addr_t    tile_addr;
    logic          tile_ack;
    tile_beat_t    tile_data;
    logic          fb_req;
    fb_addr_t      fb_addr;
    fb_word_t      fb_data;
    logic          fb_ack;
    logic          busy;
    logic          frame_done;

    obj_word_t   obj_ram [0:RAM_DEPTH-1];
    logic [15:0] stim [0:STIM_DEPTH-1];
    int          frame_count;

    // reference model state, carried across frames like the DUT
    coord_t m_master_x, m_master_y, m_extra_x, m_extra_y, m_lx, m_ly;
    color_t m_color;

    fb_addr_t exp_addr_q[$];
    fb_word_t exp_data_q[$];
    string    exp_label_q[$];

    logic [15:0] rng_state = LFSR_SEED;
    int    checks = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    writes_seen = 0;
    int    done_pulses = 0;
    string cur_test = "reset";
    logic  abort_flag = 1'b0;
    string abort_msg;

    obj_engine dut_i (
        .clk, .rst_n, .start,
        .ram_rd, .ram_addr, .ram_data,
        .tile_req, .tile_addr, .tile_ack, .tile_data,
        .fb_req, .fb_addr, .fb_data, .fb_ack,
        .busy, .frame_done
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rng_state = lfsr_next(rng_state);
            v = (v << 1) | int'(rng_state[0]);
        end
        return v;
    endfunction

    // tile contents, seeded from the whole address
    function automatic tile_beat_t tile_word(input tile_addr_t addr);
        logic [15:0] s;
        tile_beat_t  w;
        s = LFSR_SEED ^ addr[15:0] ^ {addr[18:16], 13'd0};
        if (s == 16'd0) begin
            s = LFSR_SEED;
        end
        for (int i = 0; i < 64; i++) begin
            s = lfsr_next(s);
            w[i] = s[0];
        end
        return w;
    endfunction

    function automatic logic [5:0] expected_pixel(input tile_code_t code, input int row,
                                                  input int px);
        tile_beat_t  beat;
        logic [31:0] half;
        int          k;
        beat = tile_word({code, 5'(2 * row + px / 8)});
        half = (px % 8 < 4) ? beat[31:0] : beat[63:32];
        k = px % 4;
        return {half[16+2*k +: 2], half[4*k +: 4]};
    endfunction

    task automatic load_stimulus();
        int idx;
        for (int a = 0; a < RAM_DEPTH; a++) begin
            obj_ram[obj_ram_addr_t'(a)] = '0;
        end
        for (int s = 0; s < STIM_DEPTH; s++) begin
            stim[8'(s)] = 16'hffff;
        end
        $readmemh("verification/obj_input.txt", stim);
        frame_count = int'(stim[0]);
        idx = 1;
        // triplets of entry, word, value until the ffff marker
        while (idx + 2 < STIM_DEPTH && stim[8'(idx)] != 16'hffff) begin
            obj_ram[obj_ram_addr_t'(int'(stim[8'(idx)]) * OBJ_WORDS + int'(stim[8'(idx + 1)]))]
                = stim[8'(idx + 2)];
            idx += 3;
        end
    endtask

    // walk the whole list and queue the writes one frame should make
    task automatic build_frame(input int frame);
        tile_code_t code;
        obj_word_t  attr, xw;
        coord_t     y, offs_x, offs_y, base_x, base_y, nx, ny;
        color_t     col;
        fb_word_t   w;
        logic       buf_bit;
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_label_q.delete();
        buf_bit = frame[0];
        for (int i = 0; i < OBJ_COUNT; i++) begin
            code = obj_ram[obj_ram_addr_t'(i * OBJ_WORDS)][13:0];
            attr = obj_ram[obj_ram_addr_t'(i * OBJ_WORDS + 4)];
            xw = obj_ram[obj_ram_addr_t'(i * OBJ_WORDS + 6)];
            y = obj_ram[obj_ram_addr_t'(i * OBJ_WORDS + 7)][11:0];
            offs_x = '0;
            offs_y = '0;
            if (!xw[15]) begin
                offs_x = m_master_x;
                offs_y = m_master_y;
                if (!xw[14]) begin
                    offs_x = offs_x + m_extra_x;
                    offs_y = offs_y + m_extra_y;
                end
            end
            base_x = xw[11:0] + offs_x;
            base_y = y + offs_y;
            nx = attr[14] ? m_lx : base_x;
            if (attr[15]) begin
                nx = nx + 12'd16;
            end
            ny = attr[12] ? m_ly : base_y;
            if (attr[13]) begin
                ny = ny + 12'd16;
            end
            col = attr[10] ? m_color : attr[7:0];
            if (xw[13]) begin
                m_master_x = base_x;
                m_master_y = base_y;
            end
            if (xw[12]) begin
                m_extra_x = base_x;
                m_extra_y = base_y;
            end
            m_lx = nx;
            m_ly = ny;
            m_color = col;
            if (code != '0 && nx <= X_LIMIT && ny <= Y_LIMIT) begin
                for (int r = 0; r < TILE_ROWS; r++) begin
                    for (int c = 0; c < ROW_WORDS; c++) begin
                        for (int q = 0; q < 4; q++) begin
                            w[16*q +: 16] = {4'd0, col[5:0], expected_pixel(code, r, 4 * c + q)};
                        end
                        exp_addr_q.push_back({buf_bit, 8'(ny[7:0] + 8'(r)), 7'(nx[8:2] + 7'(c))});
                        exp_data_q.push_back(w);
                        exp_label_q.push_back($sformatf("entry %0d row %0d col %0d", i, r, c));
                    end
                end
            end
        end
    endtask

    task automatic check_fb_addr(input string name, input fb_addr_t exp, input fb_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s addr: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_fb_word(input string name, input fb_word_t exp, input fb_word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s data: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic record_write(input fb_addr_t addr, input fb_word_t data);
        string name;
        writes_seen++;
        if (exp_addr_q.size() == 0) begin
            errors++;
            $display("%s: frame-buffer write to %h that the model does not expect", cur_test, addr);
        end else begin
            name = {cur_test, " ", exp_label_q.pop_front()};
            check_fb_addr(name, exp_addr_q.pop_front(), addr);
            check_fb_word(name, exp_data_q.pop_front(), data);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // hand the failure to run_guard and park this process
    task automatic abort_run(input string msg);
        abort_msg = msg;
        abort_flag = 1'b1;
        forever @(negedge clk);
    endtask

    initial begin : run_guard
        int cycles;
        cycles = 0;
        while (!abort_flag && cycles < SIM_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (abort_flag) begin
            $display("%s", abort_msg);
        end else begin
            $display("run did not finish within %0d cycles", SIM_LIMIT);
        end
        $display("Simulation FAILED");
        $finish;
    end

    // object RAM, data one cycle after the read
    initial begin : ram_model
        logic          rd_q;
        obj_ram_addr_t addr_q;
        ram_data = '0;
        rd_q = 1'b0;
        addr_q = '0;
        forever begin
            @(negedge clk);
            if (rd_q) begin
                ram_data = obj_ram[addr_q];
            end
            rd_q = ram_rd;
            addr_q = ram_addr;
        end
    end

    initial begin : tile_responder
        int cycles;
        tile_ack = 1'b0;
        tile_data = '0;
        repeat (RESET_CYCLES + 1) @(negedge clk);
        forever begin
            cycles = 0;
            while (!tile_req && cycles < IDLE_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (!tile_req) begin
                abort_run("tile memory saw no request for too long");
            end
            repeat (random_bits(2)) @(negedge clk);
            tile_data = tile_word(tile_addr);
            tile_ack = 1'b1;
            cycles = 0;
            while (tile_req && cycles < ACK_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (tile_req) begin
                abort_run("tile_req stayed high after tile_ack");
            end
            repeat (random_bits(1)) @(negedge clk);
            tile_ack = 1'b0;
        end
    end

    initial begin : fb_responder
        int cycles;
        fb_ack = 1'b0;
        repeat (RESET_CYCLES + 1) @(negedge clk);
        forever begin
            cycles = 0;
            while (!fb_req && cycles < IDLE_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (!fb_req) begin
                abort_run("frame buffer saw no write request for too long");
            end
            record_write(fb_addr, fb_data);
            repeat (random_bits(2)) @(negedge clk);
            fb_ack = 1'b1;
            cycles = 0;
            while (fb_req && cycles < ACK_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (fb_req) begin
                abort_run("fb_req stayed high after fb_ack");
            end
            repeat (random_bits(1)) @(negedge clk);
            fb_ack = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst_n && frame_done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    initial begin : main_sequence
        int cycles;
        int test_errors;
        int base_writes;
        int base_done;
        int expected;
        rst_n = 1'b0;
        start = 1'b0;
        load_stimulus();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_errors = errors;
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset frame_done", 1'b0, frame_done);
        check_flag("reset ram_rd", 1'b0, ram_rd);
        check_flag("reset tile_req", 1'b0, tile_req);
        check_flag("reset fb_req", 1'b0, fb_req);
        report_test("reset", test_errors);
        for (int f = 0; f < frame_count; f++) begin
            cur_test = $sformatf("frame%0d", f);
            test_errors = errors;
            base_writes = writes_seen;
            base_done = done_pulses;
            build_frame(f);
            expected = exp_addr_q.size();
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            check_flag({cur_test, " busy after start"}, 1'b1, busy);
            cycles = 0;
            while (done_pulses == base_done && cycles < FRAME_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (done_pulses == base_done) begin
                abort_run($sformatf("%s: no frame_done within %0d cycles", cur_test, FRAME_LIMIT));
            end
            repeat (SETTLE) @(negedge clk);
            check_count({cur_test, " frame_done pulses"}, 1, done_pulses - base_done);
            check_flag({cur_test, " busy after frame_done"}, 1'b0, busy);
            check_count({cur_test, " write count"}, expected, writes_seen - base_writes);
            report_test(cur_test, test_errors);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/obj_engine.sv ====
`timescale 1ns/1ps

module obj_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   ram_rd,
    output obj_pkg::obj_ram_addr_t ram_addr,
    input  obj_pkg::obj_word_t     ram_data,
    output logic                   tile_req,
    output obj_pkg::tile_addr_t    tile_addr,
    input  logic                   tile_ack,
    input  obj_pkg::tile_beat_t    tile_data,
    output logic                   fb_req,
    output obj_pkg::fb_addr_t      fb_addr,
    output obj_pkg::fb_word_t      fb_data,
    input  logic                   fb_ack,
    output logic                   busy,
    output logic                   frame_done
);
    import obj_pkg::*;

    // reader to evaluator
    logic       entry_valid, entry_ready, list_done;
    tile_code_t entry_code;
    obj_word_t  entry_attr, entry_x;
    coord_t     entry_y;

    // evaluator to fetch
    logic       job_valid, job_ready, job_buffer;
    tile_code_t job_code;
    coord_t     job_x, job_y;
    color_t     job_color;

    // fetch to writer
    logic       tile_valid, fetch_idle, tile_done, tile_buffer;
    logic [3:0] row_sel;
    tile_row_t  row_pixels;
    coord_t     tile_x, tile_y;
    color_t     tile_color;

    obj_list_reader reader_i (
        .clk, .rst_n, .start,
        .ram_rd, .ram_addr, .ram_data,
        .entry_valid, .entry_ready, .list_done,
        .entry_code, .entry_attr, .entry_x, .entry_y
    );

    obj_position_eval eval_i (
        .clk, .rst_n, .start,
        .entry_valid, .entry_ready,
        .entry_code, .entry_attr, .entry_x, .entry_y,
        .job_valid, .job_ready,
        .job_code, .job_x, .job_y, .job_color, .job_buffer
    );

    obj_tile_fetch fetch_i (
        .clk, .rst_n,
        .job_valid, .job_ready,
        .job_code, .job_x, .job_y, .job_color, .job_buffer,
        .tile_req, .tile_addr, .tile_ack, .tile_data,
        .tile_valid, .fetch_idle, .row_sel, .row_pixels, .tile_done,
        .tile_x, .tile_y, .tile_color, .tile_buffer
    );

    obj_fb_writer writer_i (
        .clk, .rst_n, .start,
        .list_done, .job_valid, .fetch_idle, .tile_valid,
        .row_sel, .row_pixels, .tile_done,
        .tile_x, .tile_y, .tile_color, .tile_buffer,
        .fb_req, .fb_addr, .fb_data, .fb_ack,
        .busy, .frame_done
    );

endmodule

// ==== hw/obj_fb_writer.sv ====
`timescale 1ns/1ps

module obj_fb_writer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               list_done,
    input  logic               job_valid,
    input  logic               fetch_idle,
    input  logic               tile_valid,
    output logic [3:0]         row_sel,
    input  obj_pkg::tile_row_t row_pixels,
    output logic               tile_done,
    input  obj_pkg::coord_t    tile_x,
    input  obj_pkg::coord_t    tile_y,
    input  obj_pkg::color_t    tile_color,
    input  logic               tile_buffer,
    output logic               fb_req,
    output obj_pkg::fb_addr_t  fb_addr,
    output obj_pkg::fb_word_t  fb_data,
    input  logic               fb_ack,
    output logic               busy,
    output logic               frame_done
);
    import obj_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_REQ, W_DROP} state_t;

    localparam logic [3:0] LAST_ROW = 4'(TILE_ROWS - 1);
    localparam logic [1:0] LAST_COL = 2'(ROW_WORDS - 1);

    state_t     state;
    logic [1:0] col;
    logic [7:0] line;
    logic [6:0] column;
    logic       drained;

    // line and column wrap inside the buffer
    assign line    = tile_y[7:0] + {4'd0, row_sel};
    assign column  = tile_x[8:2] + {5'd0, col};
    assign fb_addr = {tile_buffer, line, column};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fb_data[16*i +: 16] = {4'd0, tile_color[5:0], row_pixels[(4*col+i)*PIX_W +: PIX_W]};
        end
    end

    assign drained = list_done && !job_valid && fetch_idle && (state == W_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= W_IDLE;
            row_sel   <= '0;
            col       <= '0;
            fb_req    <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            case (state)
                W_IDLE: begin
                    // tile_valid is still up during the done pulse
                    if (tile_valid && !tile_done) begin
                        row_sel <= '0;
                        col     <= '0;
                        fb_req  <= 1'b1;
                        state   <= W_REQ;
                    end
                end
                W_REQ: begin
                    if (fb_ack) begin
                        fb_req <= 1'b0;
                        state  <= W_DROP;
                    end
                end
                W_DROP: begin
                    if (!fb_ack) begin
                        if (row_sel == LAST_ROW && col == LAST_COL) begin
                            tile_done <= 1'b1;
                            state     <= W_IDLE;
                        end else begin
                            col <= col + 2'd1;
                            if (col == LAST_COL) begin
                                row_sel <= row_sel + 4'd1;
                            end
                            fb_req <= 1'b1;
                            state  <= W_REQ;
                        end
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // frame status
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
            end else if (frame_done) begin
                busy <= 1'b0;
            end else if (busy && drained) begin
                frame_done <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/obj_tile_fetch.sv ====
`timescale 1ns/1ps

module obj_tile_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                job_valid,
    output logic                job_ready,
    input  obj_pkg::tile_code_t job_code,
    input  obj_pkg::coord_t     job_x,
    input  obj_pkg::coord_t     job_y,
    input  obj_pkg::color_t     job_color,
    input  logic                job_buffer,
    output logic                tile_req,
    output obj_pkg::tile_addr_t tile_addr,
    input  logic                tile_ack,
    input  obj_pkg::tile_beat_t tile_data,
    output logic                tile_valid,
    output logic                fetch_idle,
    input  logic [3:0]          row_sel,
    output obj_pkg::tile_row_t  row_pixels,
    input  logic                tile_done,
    output obj_pkg::coord_t     tile_x,
    output obj_pkg::coord_t     tile_y,
    output obj_pkg::color_t     tile_color,
    output logic                tile_buffer
);
    import obj_pkg::*;

    typedef enum logic [1:0] {F_IDLE, F_REQ, F_DROP, F_FULL} state_t;

    localparam int HALF_W = 8 * PIX_W;
    localparam logic [4:0] LAST_BEAT = 5'(TILE_BEATS - 1);

    state_t     state;
    tile_code_t code_q;
    logic [4:0] beat;
    tile_row_t  rows [TILE_ROWS];

    // low nibble and two high bits per pixel of a 32-bit half
    function automatic logic [4*PIX_W-1:0] unpack_half(input logic [31:0] d);
        logic [4*PIX_W-1:0] px;
        for (int k = 0; k < 4; k++) begin
            px[k*PIX_W +: PIX_W] = {d[16+2*k +: 2], d[4*k +: 4]};
        end
        return px;
    endfunction

    assign tile_addr  = {code_q, beat};
    assign row_pixels = rows[row_sel];
    assign job_ready  = (state == F_IDLE);
    assign fetch_idle = (state == F_IDLE);
    assign tile_valid = (state == F_FULL);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= F_IDLE;
            tile_req <= 1'b0;
            beat     <= '0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (job_valid) begin
                        beat     <= '0;
                        tile_req <= 1'b1;
                        state    <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (tile_ack) begin
                        tile_req <= 1'b0;
                        state    <= F_DROP;
                    end
                end
                F_DROP: begin
                    // wait for ack to fall before the next beat
                    if (!tile_ack) begin
                        if (beat == LAST_BEAT) begin
                            state <= F_FULL;
                        end else begin
                            beat     <= beat + 5'd1;
                            tile_req <= 1'b1;
                            state    <= F_REQ;
                        end
                    end
                end
                F_FULL: begin
                    if (tile_done) begin
                        state <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            code_q      <= job_code;
            tile_x      <= job_x;
            tile_y      <= job_y;
            tile_color  <= job_color;
            tile_buffer <= job_buffer;
        end
        // even beats fill the left half of a row, odd beats the right
        if (state == F_REQ && tile_ack) begin
            if (beat[0]) begin
                rows[beat[4:1]][2*HALF_W-1:HALF_W] <=
                    {unpack_half(tile_data[63:32]), unpack_half(tile_data[31:0])};
            end else begin
                rows[beat[4:1]][HALF_W-1:0] <=
                    {unpack_half(tile_data[63:32]), unpack_half(tile_data[31:0])};
            end
        end
    end

endmodule

// ==== hw/obj_position_eval.sv ====
`timescale 1ns/1ps

module obj_position_eval (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                entry_valid,
    output logic                entry_ready,
    input  obj_pkg::tile_code_t entry_code,
    input  obj_pkg::obj_word_t  entry_attr,
    input  obj_pkg::obj_word_t  entry_x,
    input  obj_pkg::coord_t     entry_y,
    output logic                job_valid,
    input  logic                job_ready,
    output obj_pkg::tile_code_t job_code,
    output obj_pkg::coord_t     job_x,
    output obj_pkg::coord_t     job_y,
    output obj_pkg::color_t     job_color,
    output logic                job_buffer
);
    import obj_pkg::*;

    localparam entry_idx_t LAST_ENTRY = entry_idx_t'(OBJ_COUNT - 1);

    coord_t     master_x, master_y;
    coord_t     extra_x, extra_y;
    coord_t     latch_x, latch_y;
    color_t     latch_color;
    logic       draw_buffer;
    logic       frame_open;
    entry_idx_t taken;

    logic   use_scroll, use_extra;
    coord_t offs_x, offs_y;
    coord_t base_x, base_y;
    coord_t next_x, next_y;
    color_t next_color;
    logic   drop;

    // scroll flags live in the x word for both axes
    assign use_scroll = ~entry_x[15];
    assign use_extra  = ~entry_x[14];

    always_comb begin
        offs_x = '0;
        offs_y = '0;
        if (use_scroll) begin
            offs_x = master_x + (use_extra ? extra_x : 12'd0);
            offs_y = master_y + (use_extra ? extra_y : 12'd0);
        end
        base_x = entry_x[11:0] + offs_x;
        base_y = entry_y + offs_y;
        next_x = (entry_attr[14] ? latch_x : base_x) + (entry_attr[15] ? 12'd16 : 12'd0);
        next_y = (entry_attr[12] ? latch_y : base_y) + (entry_attr[13] ? 12'd16 : 12'd0);
        next_color = entry_attr[10] ? latch_color : entry_attr[7:0];
        drop = (entry_code == '0) || (next_x > X_LIMIT) || (next_y > Y_LIMIT);
    end

    // take when the job slot is empty or draining
    assign entry_ready = entry_valid && (!job_valid || job_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            master_x    <= '0;
            master_y    <= '0;
            extra_x     <= '0;
            extra_y     <= '0;
            latch_x     <= '0;
            latch_y     <= '0;
            latch_color <= '0;
            draw_buffer <= 1'b1;
            frame_open  <= 1'b0;
            taken       <= '0;
            job_valid   <= 1'b0;
        end else begin
            if (start && !frame_open) begin
                frame_open  <= 1'b1;
                draw_buffer <= ~draw_buffer;
                taken       <= '0;
            end
            if (entry_ready) begin
                // latches move even for skipped entries
                if (entry_x[13]) begin
                    master_x <= base_x;
                    master_y <= base_y;
                end
                if (entry_x[12]) begin
                    extra_x <= base_x;
                    extra_y <= base_y;
                end
                latch_x     <= next_x;
                latch_y     <= next_y;
                latch_color <= next_color;
                taken       <= taken + 10'd1;
                if (taken == LAST_ENTRY) begin
                    frame_open <= 1'b0;
                end
                job_valid <= !drop;
            end else if (job_ready) begin
                job_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (entry_ready && !drop) begin
            job_code   <= entry_code;
            job_x      <= next_x;
            job_y      <= next_y;
            job_color  <= next_color;
            job_buffer <= draw_buffer;
        end
    end

endmodule

// ==== hw/obj_list_reader.sv ====
`timescale 1ns/1ps

module obj_list_reader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   ram_rd,
    output obj_pkg::obj_ram_addr_t ram_addr,
    input  obj_pkg::obj_word_t     ram_data,
    output logic                   entry_valid,
    input  logic                   entry_ready,
    output logic                   list_done,
    output obj_pkg::tile_code_t    entry_code,
    output obj_pkg::obj_word_t     entry_attr,
    output obj_pkg::obj_word_t     entry_x,
    output obj_pkg::coord_t        entry_y
);
    import obj_pkg::*;

    typedef enum logic [1:0] {R_IDLE, R_READ, R_WAIT, R_HOLD} state_t;

    localparam entry_idx_t LAST_ENTRY = entry_idx_t'(OBJ_COUNT - 1);

    state_t     state;
    entry_idx_t entry;
    logic [1:0] rd_idx;
    logic       cap_vld;
    logic [1:0] cap_idx;

    // read slots 0..3 map to words 0, 4, 6 and 7
    function automatic obj_ram_addr_t word_addr(input entry_idx_t idx, input logic [1:0] slot);
        logic [2:0] word;
        word = {|slot, slot[1], &slot};
        return obj_ram_addr_t'(idx * OBJ_WORDS) + obj_ram_addr_t'(word);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= R_IDLE;
            entry       <= '0;
            rd_idx      <= '0;
            ram_rd      <= 1'b0;
            ram_addr    <= '0;
            cap_vld     <= 1'b0;
            cap_idx     <= '0;
            entry_valid <= 1'b0;
            list_done   <= 1'b0;
        end else begin
            // ram data shows up one cycle after the read
            cap_vld <= ram_rd;
            cap_idx <= rd_idx;
            case (state)
                R_IDLE: begin
                    if (start) begin
                        list_done <= 1'b0;
                        entry     <= '0;
                        rd_idx    <= '0;
                        ram_rd    <= 1'b1;
                        ram_addr  <= word_addr('0, 2'd0);
                        state     <= R_READ;
                    end
                end
                R_READ: begin
                    if (rd_idx == 2'd3) begin
                        ram_rd <= 1'b0;
                        state  <= R_WAIT;
                    end else begin
                        rd_idx   <= rd_idx + 2'd1;
                        ram_addr <= word_addr(entry, rd_idx + 2'd1);
                    end
                end
                R_WAIT: begin
                    if (cap_vld && cap_idx == 2'd3) begin
                        entry_valid <= 1'b1;
                        state       <= R_HOLD;
                    end
                end
                R_HOLD: begin
                    if (entry_ready) begin
                        entry_valid <= 1'b0;
                        if (entry == LAST_ENTRY) begin
                            list_done <= 1'b1;
                            state     <= R_IDLE;
                        end else begin
                            entry    <= entry + 10'd1;
                            rd_idx   <= '0;
                            ram_rd   <= 1'b1;
                            ram_addr <= word_addr(entry + 10'd1, 2'd0);
                            state    <= R_READ;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // holding registers for the entry on offer
    always_ff @(posedge clk) begin
        if (cap_vld) begin
            case (cap_idx)
                2'd0:    entry_code <= ram_data[13:0];
                2'd1:    entry_attr <= ram_data;
                2'd2:    entry_x    <= ram_data;
                default: entry_y    <= ram_data[11:0];
            endcase
        end
    end

endmodule

// ==== hw/obj_pkg.sv ====
package obj_pkg;

    // sprite list geometry
    localparam int OBJ_COUNT = 835;
    localparam int OBJ_WORDS = 8;

    // tile and frame-buffer geometry
    localparam int TILE_ROWS  = 16;
    localparam int TILE_BEATS = 32;
    localparam int ROW_WORDS  = 4;
    localparam int PIX_W      = 6;

    typedef logic [12:0] obj_ram_addr_t;
    typedef logic [15:0] obj_word_t;
    typedef logic [9:0]  entry_idx_t;

    typedef logic [13:0] tile_code_t;
    // wraps modulo 4096
    typedef logic [11:0] coord_t;
    typedef logic [7:0]  color_t;

    // code in the upper bits, beat number in the lower five
    typedef logic [18:0] tile_addr_t;
    typedef logic [63:0] tile_beat_t;
    // pixel 0 in the lowest bits
    typedef logic [TILE_ROWS*PIX_W-1:0] tile_row_t;

    // buffer bit, line, word column
    typedef logic [15:0] fb_addr_t;
    // four 16-bit pixels, leftmost lowest
    typedef logic [63:0] fb_word_t;

    // largest drawable position
    localparam coord_t X_LIMIT = 12'd400;
    localparam coord_t Y_LIMIT = 12'd240;

endpackage
